/* cordic_coeff_unit.f */
verilog/cordic_float_pkg.sv
verilog/cordic_ctrl_pkg.sv
verilog/coeff_request_if.sv
verilog/coeff_response_if.sv
verilog/coeff_sequencer.sv
verilog/coeff_table.sv
verilog/coeff_formatter.sv
verilog/cordic_coeff_unit.sv
verification/cordic_coeff_unit_assertions.sv
verification/cordic_coeff_unit_tb.sv

/* Bender.yml */
package:
  name: cordic_coeff_unit

sources:
  - verilog/cordic_float_pkg.sv
  - verilog/cordic_ctrl_pkg.sv
  - verilog/coeff_request_if.sv
  - verilog/coeff_response_if.sv
  - verilog/coeff_sequencer.sv
  - verilog/coeff_table.sv
  - verilog/coeff_formatter.sv
  - verilog/cordic_coeff_unit.sv
  - target: test
    files:
      - verification/cordic_coeff_unit_assertions.sv
      - verification/cordic_coeff_unit_tb.sv

/* verification/cordic_coeff_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_coeff_unit_tb;

	localparam int ROW_COUNT = 13;
	localparam int TABLE_SIZE = 1024;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = ROW_COUNT * 20 + RESET_CYCLES + TABLE_SIZE + 50;
	localparam logic [31:0] ONE = 32'h3F80_0000; // 1.0
	localparam logic [31:0] K_IN = 32'h3F1B_74EE;

	logic clock;
	logic reset;
	logic start;
	logic operation;
	logic [1:0] mode;
	logic [31:0] x;
	logic [31:0] y;
	logic [31:0] z;
	logic [31:0] k;
	logic done_alu;
	logic write;
	logic [1:0] write_sel;
	logic [7:0] write_address;
	logic [31:0] write_theta;
	logic [31:0] write_kappa;
	logic [31:0] write_delta;
	logic [31:0] theta_out;
	logic [31:0] kappa_out;
	logic [31:0] delta_out;
	logic done;
	logic converged;
	logic [31:0] final_x;
	logic [31:0] final_y;
	logic [31:0] final_z;
	logic [31:0] final_k;

	string row_name [ROW_COUNT];
	logic row_operation [ROW_COUNT];
	logic [1:0] row_mode [ROW_COUNT];
	logic [31:0] row_x [ROW_COUNT];
	logic [31:0] row_y [ROW_COUNT];
	logic [31:0] row_z [ROW_COUNT];
	logic row_converged [ROW_COUNT];
	logic [31:0] row_theta [ROW_COUNT];
	logic [31:0] row_kappa [ROW_COUNT];
	logic [31:0] row_delta [ROW_COUNT];
	int row_total;
	int error_count;
	int check_count;

	cordic_coeff_unit u_cordic_coeff_unit
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.operation(operation),
		.mode(mode),
		.x(x),
		.y(y),
		.z(z),
		.k(k),
		.done_alu(done_alu),
		.write(write),
		.write_sel(write_sel),
		.write_address(write_address),
		.write_theta(write_theta),
		.write_kappa(write_kappa),
		.write_delta(write_delta),
		.theta_out(theta_out),
		.kappa_out(kappa_out),
		.delta_out(delta_out),
		.done(done),
		.converged(converged),
		.final_x(final_x),
		.final_y(final_y),
		.final_z(final_z),
		.final_k(final_k)
	);

	always #2 clock = ~clock;

	// ====================
	// helpers
	// ====================

	// word 0 theta, 1 kappa, 2 delta
	function automatic logic [31:0] table_word(input logic [1:0] word_sel, input logic [9:0] index);
		table_word = {1'b0, 8'h7A + {6'd0, word_sel}, index, 13'd0};
	endfunction

	function automatic logic [31:0] with_sign(input logic [31:0] word, input logic sign);
		with_sign = {sign, word[30:0]};
	endfunction

	function automatic logic [31:0] with_exponent(input logic [31:0] word,
		input logic [7:0] exponent);
		with_exponent = {word[31], exponent, word[22:0]};
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic add_row(input string name, input logic op, input logic [1:0] md,
		input logic [31:0] xv, input logic [31:0] yv, input logic [31:0] zv, input logic conv,
		input logic [31:0] th, input logic [31:0] ka, input logic [31:0] de);
		row_name[row_total] = name;
		row_operation[row_total] = op;
		row_mode[row_total] = md;
		row_x[row_total] = xv;
		row_y[row_total] = yv;
		row_z[row_total] = zv;
		row_converged[row_total] = conv;
		row_theta[row_total] = th;
		row_kappa[row_total] = ka;
		row_delta[row_total] = de;
		row_total++;
	endtask

	task automatic build_rows();
		row_total = 0;
		add_row("rot_converge", 1'b1, 2'd1, ONE, 32'h4000_0000, 32'h3800_0000, 1'b1, 0, 0, 0);
		add_row("vec_converge", 1'b0, 2'd3, 32'h4040_0000, 32'hBF00_0000, 32'hB000_0000, 1'b1,
			0, 0, 0);
		add_row("rot_linear", 1'b1, 2'd0, ONE, ONE, 32'h4049_0FDB, 1'b0,
			32'hC049_0FDB, ONE, 32'hC049_0FDB);
		add_row("rot_small", 1'b1, 2'd1, ONE, ONE, 32'hB912_3456, 1'b0,
			32'h3912_3456, ONE, 32'h3912_3456);
		add_row("rot_circ_const", 1'b1, 2'd1, ONE, ONE, ONE, 1'b0, cordic_ctrl_pkg::ROT_CIRC_THETA,
			cordic_ctrl_pkg::ROT_CIRC_KAPPA, cordic_ctrl_pkg::ROT_CIRC_DELTA);
		add_row("rot_hyp_const", 1'b1, 2'd3, ONE, ONE, 32'h4000_0000, 1'b0,
			cordic_ctrl_pkg::ROT_HYP_THETA, cordic_ctrl_pkg::ROT_HYP_KAPPA,
			cordic_ctrl_pkg::ROT_HYP_DELTA);
		add_row("rot_mode2_const", 1'b1, 2'd2, ONE, ONE, 32'h4120_0000, 1'b0,
			cordic_ctrl_pkg::ROT_CIRC_THETA, cordic_ctrl_pkg::ROT_CIRC_KAPPA,
			cordic_ctrl_pkg::ROT_CIRC_DELTA);
		// z exp 0x7B, mantissa top 0xA -> rotation table address 0x4A
		add_row("rot_lookup", 1'b1, 2'd1, ONE, ONE, 32'h3DD0_0000, 1'b0,
			with_sign(table_word(0, 10'h14A), 1'b1), table_word(1, 10'h14A),
			with_sign(table_word(2, 10'h14A), 1'b1));
		// e = 0x20 - 0x7F = 0xA1, patched exponent 0x20
		add_row("vec_general", 1'b0, 2'd1, 32'h1018_0000, 32'h3FE0_0000, ONE, 1'b0,
			with_exponent(table_word(0, 10'h03C), 8'h20), ONE,
			with_exponent(table_word(2, 10'h03C), 8'h20));
		add_row("vec_linear", 1'b0, 2'd0, ONE, ONE, ONE, 1'b0,
			with_exponent(table_word(0, 10'h000), 8'h7F), ONE,
			with_exponent(table_word(2, 10'h000), 8'h7F));
		// e = 0xFD, vectoring table address 0xD9
		add_row("vec_far", 1'b0, 2'd1, 32'h3EC0_0000, 32'h4020_0000, ONE, 1'b0,
			table_word(0, 10'h2D9), table_word(1, 10'h2D9), table_word(2, 10'h2D9));
		add_row("vec_circ_const", 1'b0, 2'd1, ONE, ONE, ONE, 1'b0, cordic_ctrl_pkg::VEC_CIRC_THETA,
			cordic_ctrl_pkg::VEC_CIRC_KAPPA, cordic_ctrl_pkg::VEC_CIRC_DELTA);
		add_row("vec_hyp_const", 1'b0, 2'd3, 32'h4000_0000, 32'h0040_0000, ONE, 1'b0,
			cordic_ctrl_pkg::VEC_HYP_THETA, cordic_ctrl_pkg::VEC_HYP_KAPPA,
			cordic_ctrl_pkg::VEC_HYP_DELTA);
	endtask

	task automatic load_table();
		for (int i = 0; i < TABLE_SIZE; i++)
		begin
			write = 1'b1;
			{write_sel, write_address} = i[9:0];
			write_theta = table_word(0, i[9:0]);
			write_kappa = table_word(1, i[9:0]);
			write_delta = table_word(2, i[9:0]);
			next_cycle();
		end
		write = 1'b0;
	endtask

	task automatic run_row(input int i);
		operation = row_operation[i];
		mode = row_mode[i];
		x = row_x[i];
		y = row_y[i];
		z = row_z[i];
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		check_value({row_name[i], " converged"}, row_converged[i], converged);
		check_value({row_name[i], " done early"}, 0, done);
		if (row_converged[i])
		begin
			check_value({row_name[i], " final_x"}, row_x[i], final_x);
			check_value({row_name[i], " final_y"}, row_y[i], final_y);
			check_value({row_name[i], " final_z"}, row_z[i], final_z);
			check_value({row_name[i], " final_k"}, K_IN, final_k);
		end
		next_cycle();
		check_value({row_name[i], " converged pulse"}, 0, converged);
		check_value({row_name[i], " done early"}, 0, done);
		next_cycle();
		check_value({row_name[i], " done"}, !row_converged[i], done);
		if (!row_converged[i])
		begin
			check_value({row_name[i], " theta"}, row_theta[i], theta_out);
			check_value({row_name[i], " kappa"}, row_kappa[i], kappa_out);
			check_value({row_name[i], " delta"}, row_delta[i], delta_out);
			next_cycle();
			next_cycle();
			check_value({row_name[i], " done held"}, 1, done); // no acknowledge yet
			done_alu = 1'b1;
			next_cycle();
			done_alu = 1'b0;
			check_value({row_name[i], " done cleared"}, 0, done);
		end
	endtask

	// ====================
	// main sequence
	// ====================

	initial
	begin
		error_count = 0;
		check_count = 0;
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		operation = 1'b0;
		mode = 2'd0;
		x = '0;
		y = '0;
		z = '0;
		k = K_IN;
		done_alu = 1'b0;
		write = 1'b0;
		write_sel = 2'd0;
		write_address = 8'd0;
		write_theta = '0;
		write_kappa = '0;
		write_delta = '0;
		build_rows();
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		check_value("reset done", 0, done);
		check_value("reset theta", 0, theta_out);
		check_value("reset final_x", 0, final_x);
		load_table();
		for (int i = 0; i < ROW_COUNT; i++)
			run_row(i);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("watchdog expired before all rows were applied");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/cordic_coeff_unit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_coeff_unit_assertions
(
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire logic [31:0] z,
	input wire logic done_alu,
	input wire logic done,
	input wire logic converged
);

	logic converging;

	assign converging = (z[30:23] <= 8'h70); // z exponent at convergence threshold

	assert property (@(posedge clock) disable iff (reset) start && !converging |-> ##3 done)
		else $error("done did not rise three cycles after start");

	assert property (@(posedge clock) disable iff (reset) $rose(done) |-> $past(start, 3))
		else $error("done rose without a start three cycles earlier");

	assert property (@(posedge clock) disable iff (reset) converged && !start |=> !converged)
		else $error("converged held for more than one cycle");

	// no result in flight when start was low two cycles back
	assert property (@(posedge clock) disable iff (reset)
		done && done_alu && !$past(start, 2) |=> !done)
		else $error("done stayed high after done_alu");

endmodule

bind cordic_coeff_unit cordic_coeff_unit_assertions u_cordic_coeff_unit_assertions
(
	.clock(clock),
	.reset(reset),
	.start(start),
	.z(z),
	.done_alu(done_alu),
	.done(done),
	.converged(converged)
);

`default_nettype wire

/* verilog/cordic_coeff_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_coeff_unit
(
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire logic operation,
	input wire logic [1:0] mode,
	input wire cordic_float_pkg::fp32_word x,
	input wire cordic_float_pkg::fp32_word y,
	input wire cordic_float_pkg::fp32_word z,
	input wire cordic_float_pkg::fp32_word k,
	input wire logic done_alu,
	input wire logic write,
	input wire logic [1:0] write_sel,
	input wire logic [7:0] write_address,
	input wire cordic_float_pkg::fp32_word write_theta,
	input wire cordic_float_pkg::fp32_word write_kappa,
	input wire cordic_float_pkg::fp32_word write_delta,
	output cordic_float_pkg::fp32_word theta_out,
	output cordic_float_pkg::fp32_word kappa_out,
	output cordic_float_pkg::fp32_word delta_out,
	output logic done,
	output logic converged,
	output logic [31:0] final_x,
	output logic [31:0] final_y,
	output logic [31:0] final_z,
	output logic [31:0] final_k
);

	coeff_request_if request_bus ();
	coeff_response_if response_bus ();

	coeff_sequencer u_coeff_sequencer
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.operation(operation),
		.mode(mode),
		.x(x),
		.y(y),
		.z(z),
		.k(k),
		.final_x(final_x),
		.final_y(final_y),
		.final_z(final_z),
		.final_k(final_k),
		.converged(converged),
		.request(request_bus.producer)
	);

	coeff_table u_coeff_table
	(
		.clock(clock),
		.reset(reset),
		.write(write),
		.write_sel(write_sel),
		.write_address(write_address),
		.write_theta(write_theta),
		.write_kappa(write_kappa),
		.write_delta(write_delta),
		.request(request_bus.consumer),
		.response(response_bus.producer)
	);

	coeff_formatter u_coeff_formatter
	(
		.clock(clock),
		.reset(reset),
		.done_alu(done_alu),
		.response(response_bus.consumer),
		.theta_out(theta_out),
		.kappa_out(kappa_out),
		.delta_out(delta_out),
		.done(done)
	);

endmodule

`default_nettype wire

/* verilog/coeff_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module coeff_formatter
(
	input wire logic clock,
	input wire logic reset,
	input wire logic done_alu,
	coeff_response_if.consumer response,
	output cordic_float_pkg::fp32_word theta_out,
	output cordic_float_pkg::fp32_word kappa_out,
	output cordic_float_pkg::fp32_word delta_out,
	output logic done
);

	cordic_float_pkg::fp32_word theta_fmt;
	cordic_float_pkg::fp32_word kappa_fmt;
	cordic_float_pkg::fp32_word delta_fmt;

	always_comb
	begin
		theta_fmt = response.theta;
		kappa_fmt = response.kappa;
		delta_fmt = response.delta;
		case (response.kind)
			cordic_ctrl_pkg::KIND_SIGN:
			begin
				theta_fmt.f.sign = response.sign;
				delta_fmt.f.sign = response.sign;
			end
			cordic_ctrl_pkg::KIND_EXPONENT:
			begin
				theta_fmt.f.exponent = response.exponent;
				delta_fmt.f.exponent = response.exponent;
				kappa_fmt = cordic_float_pkg::FP_ONE;
			end
			default:; // direct and raw words unchanged
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			theta_out <= '0;
			kappa_out <= '0;
			delta_out <= '0;
			done <= 1'b0;
		end
		else if (response.valid)
		begin
			theta_out <= theta_fmt;
			kappa_out <= kappa_fmt;
			delta_out <= delta_fmt;
			done <= 1'b1; // new result beats done_alu
		end
		else if (done_alu)
			done <= 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/coeff_table.sv */
`timescale 1ns/1ps
`default_nettype none

module coeff_table
(
	input wire logic clock,
	input wire logic reset,
	input wire logic write,
	input wire logic [1:0] write_sel,
	input wire logic [7:0] write_address,
	input wire cordic_float_pkg::fp32_word write_theta,
	input wire cordic_float_pkg::fp32_word write_kappa,
	input wire cordic_float_pkg::fp32_word write_delta,
	coeff_request_if.consumer request,
	coeff_response_if.producer response
);

	cordic_float_pkg::fp32_word theta_mem [0:1023];
	cordic_float_pkg::fp32_word kappa_mem [0:1023];
	cordic_float_pkg::fp32_word delta_mem [0:1023];

	logic [9:0] read_index;
	logic [9:0] write_index;

	assign read_index = {request.table_sel, request.address};
	assign write_index = {write_sel, write_address};

	always_ff @(posedge clock)
	begin
		if (write)
		begin
			theta_mem[write_index] <= write_theta;
			kappa_mem[write_index] <= write_kappa;
			delta_mem[write_index] <= write_delta;
		end
		if (request.valid)
		begin
			response.kind <= request.kind;
			response.sign <= request.sign;
			response.exponent <= request.exponent;
			response.theta <= request.lookup ? theta_mem[read_index] : request.theta;
			response.kappa <= request.lookup ? kappa_mem[read_index] : request.kappa;
			response.delta <= request.lookup ? delta_mem[read_index] : request.delta;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			response.valid <= 1'b0;
		else
			response.valid <= request.valid;
	end

endmodule

`default_nettype wire

/* verilog/coeff_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module coeff_sequencer
(
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire logic operation,
	input wire logic [1:0] mode,
	input wire cordic_float_pkg::fp32_word x,
	input wire cordic_float_pkg::fp32_word y,
	input wire cordic_float_pkg::fp32_word z,
	input wire cordic_float_pkg::fp32_word k,
	output cordic_float_pkg::fp32_word final_x,
	output cordic_float_pkg::fp32_word final_y,
	output cordic_float_pkg::fp32_word final_z,
	output cordic_float_pkg::fp32_word final_k,
	output logic converged,
	coeff_request_if.producer request
);

	logic [7:0] z_exp;
	logic [7:0] rot_shift;
	logic [7:0] vec_e;
	logic is_linear;
	logic is_hyp;

	logic next_valid;
	logic next_lookup;
	logic next_converged;
	logic [1:0] next_kind;
	logic [1:0] next_sel;
	logic [7:0] next_address;
	cordic_float_pkg::fp32_word next_theta;
	cordic_float_pkg::fp32_word next_kappa;
	cordic_float_pkg::fp32_word next_delta;

	assign z_exp = z.f.exponent;
	assign rot_shift = cordic_float_pkg::FP_EXP_BIAS - z_exp;
	assign vec_e = x.f.exponent - y.f.exponent; // wraps mod 256
	assign is_linear = (mode == cordic_ctrl_pkg::MODE_LINEAR);
	assign is_hyp = (mode == cordic_ctrl_pkg::MODE_HYPERBOLIC);

	// ====================
	// request decode
	// ====================

	always_comb
	begin
		next_valid = 1'b0;
		next_lookup = 1'b0;
		next_converged = 1'b0;
		next_kind = cordic_ctrl_pkg::KIND_DIRECT;
		next_sel = cordic_ctrl_pkg::TABLE_GENERAL;
		next_address = {x.f.mantissa[22:19], y.f.mantissa[22:19]};
		next_theta = {1'b0, z.raw[30:0]}; // magnitude only
		next_kappa = cordic_float_pkg::FP_ONE;
		next_delta = {1'b0, z.raw[30:0]};
		if (start)
		begin
			if (z_exp <= cordic_ctrl_pkg::CONVERGE_EXP)
				next_converged = 1'b1;
			else
			begin
				next_valid = 1'b1;
				case (operation)
					cordic_ctrl_pkg::OP_ROTATION:
					begin
						if (is_linear || z_exp <= cordic_ctrl_pkg::LOOKUP_LOW_EXP)
							next_kind = cordic_ctrl_pkg::KIND_SIGN;
						else if (z_exp >= cordic_float_pkg::FP_EXP_BIAS)
						begin
							next_theta = is_hyp ? cordic_ctrl_pkg::ROT_HYP_THETA
								: cordic_ctrl_pkg::ROT_CIRC_THETA;
							next_kappa = is_hyp ? cordic_ctrl_pkg::ROT_HYP_KAPPA
								: cordic_ctrl_pkg::ROT_CIRC_KAPPA;
							next_delta = is_hyp ? cordic_ctrl_pkg::ROT_HYP_DELTA
								: cordic_ctrl_pkg::ROT_CIRC_DELTA;
						end
						else
						begin
							next_lookup = 1'b1;
							next_kind = cordic_ctrl_pkg::KIND_SIGN;
							next_sel = cordic_ctrl_pkg::TABLE_ROTATION;
							next_address = {rot_shift[3:0], z.f.mantissa[22:19]};
						end
					end
					cordic_ctrl_pkg::OP_VECTORING:
					begin
						if (is_linear || (vec_e > cordic_ctrl_pkg::VEC_NEAR_EXP
							&& vec_e <= cordic_ctrl_pkg::VEC_FAR_EXP))
						begin
							next_lookup = 1'b1;
							next_kind = cordic_ctrl_pkg::KIND_EXPONENT;
						end
						else if (vec_e > cordic_ctrl_pkg::VEC_FAR_EXP)
						begin
							next_lookup = 1'b1;
							next_kind = cordic_ctrl_pkg::KIND_RAW;
							next_sel = cordic_ctrl_pkg::TABLE_VECTORING;
							next_address = {vec_e[3:0], x.f.mantissa[22:21], y.f.mantissa[22:21]};
						end
						else
						begin
							next_theta = is_hyp ? cordic_ctrl_pkg::VEC_HYP_THETA
								: cordic_ctrl_pkg::VEC_CIRC_THETA;
							next_kappa = is_hyp ? cordic_ctrl_pkg::VEC_HYP_KAPPA
								: cordic_ctrl_pkg::VEC_CIRC_KAPPA;
							next_delta = is_hyp ? cordic_ctrl_pkg::VEC_HYP_DELTA
								: cordic_ctrl_pkg::VEC_CIRC_DELTA;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			request.valid <= 1'b0;
			request.lookup <= 1'b0;
			converged <= 1'b0;
			final_x <= '0;
			final_y <= '0;
			final_z <= '0;
			final_k <= '0;
		end
		else
		begin
			request.valid <= next_valid;
			request.lookup <= next_lookup;
			converged <= next_converged;
			if (next_converged)
			begin
				final_x <= x;
				final_y <= y;
				final_z <= z;
				final_k <= k;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (next_valid)
		begin
			request.kind <= next_kind;
			request.table_sel <= next_sel;
			request.address <= next_address;
			request.theta <= next_theta;
			request.kappa <= next_kappa;
			request.delta <= next_delta;
			request.sign <= ~z.f.sign;
			request.exponent <= vec_e + cordic_float_pkg::FP_EXP_BIAS; // e + bias
		end
	end

endmodule

`default_nettype wire

/* verilog/coeff_response_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface coeff_response_if;

	logic valid;
	logic [1:0] kind; // tells the formatter which field to patch
	cordic_float_pkg::fp32_word theta;
	cordic_float_pkg::fp32_word kappa;
	cordic_float_pkg::fp32_word delta;
	logic sign;
	logic [7:0] exponent;

	modport producer (output valid, kind, theta, kappa, delta, sign, exponent);
	modport consumer (input valid, kind, theta, kappa, delta, sign, exponent);

endinterface

`default_nettype wire

/* verilog/coeff_request_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface coeff_request_if;

	logic valid; // one cycle per request
	logic lookup; // qualifies valid
	logic [1:0] kind;
	logic [1:0] table_sel;
	logic [7:0] address;
	cordic_float_pkg::fp32_word theta;
	cordic_float_pkg::fp32_word kappa;
	cordic_float_pkg::fp32_word delta;
	logic sign;
	logic [7:0] exponent;

	modport producer (output valid, lookup, kind, table_sel, address, theta, kappa, delta,
		sign, exponent);
	modport consumer (input valid, lookup, kind, table_sel, address, theta, kappa, delta,
		sign, exponent);

endinterface

`default_nettype wire

/* verilog/cordic_ctrl_pkg.sv */
`default_nettype none

package cordic_ctrl_pkg;

	localparam logic [1:0] MODE_LINEAR = 2'd0;
	localparam logic [1:0] MODE_CIRCULAR = 2'd1; // code 2 behaves the same
	localparam logic [1:0] MODE_HYPERBOLIC = 2'd3;

	localparam logic OP_ROTATION = 1'b1;
	localparam logic OP_VECTORING = 1'b0;

	localparam logic [1:0] TABLE_GENERAL = 2'd0;
	localparam logic [1:0] TABLE_ROTATION = 2'd1;
	localparam logic [1:0] TABLE_VECTORING = 2'd2;

	localparam logic [1:0] KIND_DIRECT = 2'd0; // words used as they are
	localparam logic [1:0] KIND_SIGN = 2'd1; // sign of theta and delta replaced
	localparam logic [1:0] KIND_EXPONENT = 2'd2; // exponent of theta and delta replaced
	localparam logic [1:0] KIND_RAW = 2'd3; // table entry used as it is

	// ====================
	// exponent thresholds
	// ====================

	localparam logic [7:0] CONVERGE_EXP = 8'h70;
	localparam logic [7:0] LOOKUP_LOW_EXP = 8'h73;
	localparam logic [7:0] VEC_NEAR_EXP = 8'h80;
	localparam logic [7:0] VEC_FAR_EXP = 8'hF3;

	// ====================
	// constant coefficient sets
	// ====================

	localparam logic [31:0] ROT_CIRC_THETA = 32'hBF80_0000;
	localparam logic [31:0] ROT_CIRC_KAPPA = 32'h3FEC_E788;
	localparam logic [31:0] ROT_CIRC_DELTA = 32'hBFC7_5923;
	localparam logic [31:0] ROT_HYP_THETA = 32'hBF80_0000;
	localparam logic [31:0] ROT_HYP_KAPPA = 32'h3FC5_83AB;
	localparam logic [31:0] ROT_HYP_DELTA = 32'hBF42_F7D6;
	localparam logic [31:0] VEC_CIRC_THETA = 32'h3F49_0FDB; // pi/4
	localparam logic [31:0] VEC_CIRC_KAPPA = 32'h3FB5_04F4;
	localparam logic [31:0] VEC_CIRC_DELTA = 32'h3F80_0000;
	localparam logic [31:0] VEC_HYP_THETA = 32'h3FEA_77CB;
	localparam logic [31:0] VEC_HYP_KAPPA = 32'h3E9F_DF38;
	localparam logic [31:0] VEC_HYP_DELTA = 32'h3F73_3333;

endpackage

`default_nettype wire

/* verilog/cordic_float_pkg.sv */
`default_nettype none

package cordic_float_pkg;

	// ====================
	// ieee single precision word
	// ====================

	typedef struct packed
	{
		logic sign;
		logic [7:0] exponent;
		logic [22:0] mantissa;
	} fp32_fields;

	typedef union packed
	{
		logic [31:0] raw;
		fp32_fields f;
	} fp32_word;

	localparam logic [31:0] FP_ONE = 32'h3F80_0000; // 1.0
	localparam logic [7:0] FP_EXP_BIAS = 8'h7F;

endpackage

`default_nettype wire
